// ==== sim.f ====
verilog/stall_event_pkg.sv
verilog/trace_pkg.sv
verilog/stall_attrib_pipe.sv
verilog/stall_histogram.sv
verilog/trace_emitter.sv
verilog/core_profiler.sv
sim/core_profiler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core profiler testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module core_profiler_tb \
  -f sim.f \
  -o core_profiler_sim

./obj_dir/core_profiler_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Run reported failure, see sim.log"
  exit 1
fi

echo "Run completed without failure"
exit 0

// ==== sim/core_profiler_tb.sv ====
`timescale 1ns/10ps

module core_profiler_tb
  import stall_event_pkg::*;
  import trace_pkg::*;
();

  localparam int CLK_PERIOD  = 10;
  localparam int RANDOM_ROWS = 200;

  logic                   clk_i;
  logic                   rst_i;
  logic                   freeze_i;
  logic [NUM_REASONS-1:0] stall_events_i;
  logic                   commit_v_i;
  logic [PC_WIDTH-1:0]    commit_pc_i;
  stall_reason_e          hist_sel_i;
  logic                   trace_credit_i;
  logic [HIST_WIDTH-1:0]  hist_count_o;
  logic                   trace_v_o;
  logic                   trace_kind_o;
  logic [CYCLE_WIDTH-1:0] trace_cycle_o;
  trace_payload_u         trace_payload_o;
  logic [DROP_WIDTH-1:0]  drop_count_o;

  // Stimulus table, one entry per clock cycle
  int                     row_test [$];
  logic [NUM_REASONS-1:0] row_events [$];
  logic                   row_commit [$];
  logic [PC_WIDTH-1:0]    row_pc [$];
  logic                   row_freeze [$];
  logic                   row_credit [$];

  string test_names [8] = '{"reset", "attribution delay", "priority", "retirement",
                            "credits", "freeze", "random", "histogram"};

  // Reference model state
  logic [NUM_REASONS-1:0] ahead [NUM_STAGES];
  logic                   model_commit_v;
  logic [PC_WIDTH-1:0]    model_commit_pc;
  int                     model_credit;
  logic [CYCLE_WIDTH-1:0] model_cycle;
  logic [DROP_WIDTH-1:0]  model_drop;
  logic [HIST_WIDTH-1:0]  model_hist [NUM_REASONS];

  int     errors;
  int     test_start;
  int     tests_failed;
  int     num_rows;
  bit     table_ready;
  integer seed;

  core_profiler dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .freeze_i        (freeze_i),
    .stall_events_i  (stall_events_i),
    .commit_v_i      (commit_v_i),
    .commit_pc_i     (commit_pc_i),
    .hist_sel_i      (hist_sel_i),
    .trace_credit_i  (trace_credit_i),
    .hist_count_o    (hist_count_o),
    .trace_v_o       (trace_v_o),
    .trace_kind_o    (trace_kind_o),
    .trace_cycle_o   (trace_cycle_o),
    .trace_payload_o (trace_payload_o),
    .drop_count_o    (drop_count_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // Reasons that hold the instruction in each stage, IF1 first
  function automatic logic [NUM_REASONS-1:0] stage_reasons(input int s);
    case (s)
      0: return 25'h1f8_800e;
      1: return 25'h159_a00e;
      2: return 25'h05e_a02e;
      3: return 25'h010_7f7e;
      4: return 25'h000_302e;
      5: return 25'h000_102e;
      default: return '0;
    endcase
  endfunction

  function automatic stall_reason_e lowest_reason(input logic [NUM_REASONS-1:0] vec);
    for (int i = 0; i < NUM_REASONS; i++)
    begin
      if (vec[i])
      begin
        return stall_reason_e'(i);
      end
    end
    return e_unknown;
  endfunction

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      errors++;
    end
  endtask

  task automatic add_row(input int test, input logic [NUM_REASONS-1:0] ev, input logic cv,
                         input logic [PC_WIDTH-1:0] pc, input logic frz, input logic cred);
    row_test.push_back(test);
    row_events.push_back(ev);
    row_commit.push_back(cv);
    row_pc.push_back(pc);
    row_freeze.push_back(frz);
    row_credit.push_back(cred);
  endtask

  task automatic add_idle(input int test, input int count, input logic cred);
    for (int i = 0; i < count; i++)
    begin
      add_row(test, '0, 1'b0, '0, 1'b0, cred);
    end
  endtask

  task automatic build_table();
    logic [NUM_REASONS-1:0] ev;
    logic [PC_WIDTH-1:0]    pc;
    logic                   cv;
    logic                   frz;
    logic                   cred;
    // IF1 only, then EX1 to EX3
    add_row(1, 25'd1 << e_icache_miss, 1'b0, '0, 1'b0, 1'b1);
    add_idle(1, 10, 1'b1);
    add_row(1, 25'd1 << e_control_haz, 1'b0, '0, 1'b0, 1'b1);
    add_idle(1, 10, 1'b1);
    add_row(2, (25'd1 << e_exception) | (25'd1 << e_dcache_miss), 1'b0, '0, 1'b0, 1'b1);
    add_idle(2, 10, 1'b1);
    add_row(3, '0, 1'b1, 39'h40_0000_1000, 1'b0, 1'b1);
    add_row(3, 25'd1 << e_load_dep, 1'b1, 39'h40_0000_1004, 1'b0, 1'b1);
    add_row(3, 25'd1 << e_mul_dep, 1'b0, '0, 1'b0, 1'b1);
    add_row(3, '0, 1'b1, 39'h7f_ffff_fffc, 1'b0, 1'b1);
    add_idle(3, 8, 1'b1);
    // Receiver holds back its credits
    for (int i = 0; i < 8; i++)
    begin
      add_row(4, 25'd1 << e_struct_haz, 1'b0, '0, 1'b0, 1'b0);
    end
    add_idle(4, 6, 1'b1);
    add_row(5, 25'd1 << e_itlb_miss, 1'b0, '0, 1'b0, 1'b1);
    for (int i = 0; i < 4; i++)
    begin
      add_row(5, (25'd1 << e_dcache_miss) | (25'd1 << e_interrupt), 1'b0, '0, 1'b1, 1'b1);
    end
    add_idle(5, 10, 1'b1);
    for (int i = 0; i < RANDOM_ROWS; i++)
    begin
      ev   = 25'($random(seed)) & 25'($random(seed)) & 25'($random(seed));
      cv   = (($random(seed) & 3) == 0);
      pc   = 39'({$random(seed), $random(seed)});
      frz  = (($random(seed) & 15) == 0);
      cred = (($random(seed) & 3) != 0);
      add_row(6, ev, cv, pc, frz, cred);
    end
  endtask

  task automatic apply_row(input int idx);
    stall_events_i = row_events[idx];
    commit_v_i     = row_commit[idx];
    commit_pc_i    = row_pc[idx];
    freeze_i       = row_freeze[idx];
    trace_credit_i = row_credit[idx];
  endtask

  // One clock edge of the model, compared against the DUT right after it
  task automatic step_and_compare(input int idx);
    stall_reason_e reason;
    logic          frz;
    logic          send;
    frz    = row_freeze[idx];
    reason = lowest_reason(ahead[0]);
    send   = !frz && (model_credit > 0);
    check("trace_v_o", 64'(trace_v_o), 64'(send));
    if (send && trace_v_o === 1'b1)
    begin
      check("trace_cycle_o", 64'(trace_cycle_o), 64'(model_cycle));
      if (model_commit_v)
      begin
        check("trace_kind_o", 64'(trace_kind_o), 64'(TRACE_KIND_INSTR));
        check("trace_payload_o.pc", 64'(trace_payload_o.pc), 64'(model_commit_pc));
      end
      else
      begin
        check("trace_kind_o", 64'(trace_kind_o), 64'(TRACE_KIND_STALL));
        check("trace_payload_o.code", 64'(trace_payload_o.stall.code), 64'(reason));
        check("trace_payload_o.pad", 64'(trace_payload_o.stall.pad), 64'(0));
      end
    end
    if (!frz && !send)
    begin
      model_drop = model_drop + 1;
    end
    if (!frz && !model_commit_v)
    begin
      model_hist[reason] = model_hist[reason] + 1;
    end
    check("drop_count_o", 64'(drop_count_o), 64'(model_drop));
    model_credit = model_credit - int'(send) + int'(row_credit[idx]);
    if (model_credit > TRACE_CREDITS)
    begin
      model_credit = TRACE_CREDITS;
    end
    model_cycle = model_cycle + 1'b1;
    // A stage s event shows up 8 - s edges later, freeze loses it all
    for (int k = 0; k < NUM_STAGES; k++)
    begin
      ahead[k] = (k < NUM_STAGES - 1) ? ahead[k+1] : '0;
    end
    for (int s = 0; s < NUM_STAGES; s++)
    begin
      ahead[NUM_STAGES-1-s] = ahead[NUM_STAGES-1-s] | (row_events[idx] & stage_reasons(s));
    end
    if (frz)
    begin
      for (int k = 0; k < NUM_STAGES; k++)
      begin
        ahead[k] = '0;
      end
    end
    model_commit_v  = row_commit[idx];
    model_commit_pc = row_pc[idx];
  endtask

  task automatic report_test(input int id);
    if (errors == test_start)
    begin
      $display("test %0d %s: ok", id, test_names[id]);
    end
    else
    begin
      $display("test %0d %s: %0d mismatches", id, test_names[id], errors - test_start);
      tests_failed++;
    end
    test_start = errors;
  endtask

  initial
  begin
    seed           = 32'h6537_b12c;
    errors         = 0;
    test_start     = 0;
    tests_failed   = 0;
    rst_i          = 1'b1;
    freeze_i       = 1'b0;
    stall_events_i = '0;
    commit_v_i     = 1'b0;
    commit_pc_i    = '0;
    hist_sel_i     = e_unknown;
    trace_credit_i = 1'b0;
    build_table();
    num_rows    = row_test.size();
    table_ready = 1'b1;
    for (int k = 0; k < NUM_STAGES; k++)
    begin
      ahead[k] = '0;
    end
    for (int i = 0; i < NUM_REASONS; i++)
    begin
      model_hist[i] = '0;
    end
    model_commit_v  = 1'b0;
    model_commit_pc = '0;
    model_credit    = TRACE_CREDITS;
    model_cycle     = '0;
    model_drop      = '0;
    repeat (5) @(posedge clk_i);
    #1;
    check("trace_v_o", 64'(trace_v_o), 64'(0));
    check("drop_count_o", 64'(drop_count_o), 64'(0));
    report_test(0);
    rst_i = 1'b0;
    apply_row(0);
    for (int r = 1; r <= num_rows; r++)
    begin
      @(posedge clk_i);
      #1;
      step_and_compare(r - 1);
      if (r == num_rows || row_test[r] != row_test[r-1])
      begin
        report_test(row_test[r-1]);
      end
      if (r < num_rows)
      begin
        apply_row(r);
      end
    end
    // Hold the counters still while reading them out
    freeze_i = 1'b1;
    for (int i = 0; i < NUM_REASONS; i++)
    begin
      hist_sel_i = stall_reason_e'(i);
      #1;
      check("hist_count_o", 64'(hist_count_o), 64'(model_hist[i]));
    end
    report_test(7);
    $display("%0d tests, %0d failed, %0d mismatches", 8, tests_failed, errors);
    if (errors == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Generous bound on the whole run
  initial
  begin
    int limit_cycles;
    wait (table_ready);
    limit_cycles = 20 * (num_rows - RANDOM_ROWS) + RANDOM_ROWS + 5 + NUM_REASONS;
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== verilog/core_profiler.sv ====
`timescale 1ns/10ps

module core_profiler
  import stall_event_pkg::*;
  import trace_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   freeze_i,
  input  logic [NUM_REASONS-1:0] stall_events_i,
  input  logic                   commit_v_i,
  input  logic [PC_WIDTH-1:0]    commit_pc_i,
  input  stall_reason_e          hist_sel_i,
  input  logic                   trace_credit_i,
  output logic [HIST_WIDTH-1:0]  hist_count_o,
  output logic                   trace_v_o,
  output logic                   trace_kind_o,
  output logic [CYCLE_WIDTH-1:0] trace_cycle_o,
  output trace_payload_u         trace_payload_o,
  output logic [DROP_WIDTH-1:0]  drop_count_o
);

  logic                   commit_v_r;
  logic [PC_WIDTH-1:0]    commit_pc_r;
  logic [NUM_REASONS-1:0] attrib_vec;
  stall_reason_e          reason_code;

  // Commit arrives one cycle late, as the trap packet does
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      commit_v_r <= 1'b0;
    end
    else
    begin
      commit_v_r <= commit_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    commit_pc_r <= commit_pc_i;
  end

  stall_attrib_pipe u_attrib_pipe (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .freeze_i       (freeze_i),
    .stall_events_i (stall_events_i),
    .attrib_vec_o   (attrib_vec)
  );

  stall_histogram u_histogram (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .freeze_i      (freeze_i),
    .attrib_vec_i  (attrib_vec),
    .commit_v_i    (commit_v_r),
    .hist_sel_i    (hist_sel_i),
    .reason_code_o (reason_code),
    .hist_count_o  (hist_count_o)
  );

  trace_emitter u_trace_emitter (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .freeze_i        (freeze_i),
    .commit_v_i      (commit_v_r),
    .commit_pc_i     (commit_pc_r),
    .reason_code_i   (reason_code),
    .trace_credit_i  (trace_credit_i),
    .trace_v_o       (trace_v_o),
    .trace_kind_o    (trace_kind_o),
    .trace_cycle_o   (trace_cycle_o),
    .trace_payload_o (trace_payload_o),
    .drop_count_o    (drop_count_o)
  );

endmodule

// ==== verilog/trace_emitter.sv ====
`timescale 1ns/10ps

module trace_emitter
  import stall_event_pkg::*;
  import trace_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   freeze_i,
  input  logic                   commit_v_i,
  input  logic [PC_WIDTH-1:0]    commit_pc_i,
  input  stall_reason_e          reason_code_i,
  input  logic                   trace_credit_i,
  output logic                   trace_v_o,
  output logic                   trace_kind_o,
  output logic [CYCLE_WIDTH-1:0] trace_cycle_o,
  output trace_payload_u         trace_payload_o,
  output logic [DROP_WIDTH-1:0]  drop_count_o
);

  logic [CYCLE_WIDTH-1:0]  cycle_r;
  logic [CREDIT_WIDTH-1:0] credit_r;
  logic [CREDIT_WIDTH-1:0] credit_n;
  logic                    send;
  logic                    drop;
  trace_payload_u          payload_n;

  // Free running, freeze does not stop it
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cycle_r <= '0;
    end
    else
    begin
      cycle_r <= cycle_r + 1'b1;
    end
  end

  assign send = ~freeze_i & (credit_r != '0);
  assign drop = ~freeze_i & (credit_r == '0);

  always_comb
  begin
    credit_n = credit_r - CREDIT_WIDTH'(send) + CREDIT_WIDTH'(trace_credit_i);
    // Receiver never returns more than it was given
    if (credit_n > CREDIT_WIDTH'(TRACE_CREDITS))
    begin
      credit_n = CREDIT_WIDTH'(TRACE_CREDITS);
    end
  end

  always_comb
  begin
    payload_n = '0;
    if (commit_v_i)
    begin
      payload_n.pc = commit_pc_i;
    end
    else
    begin
      payload_n.stall.code = reason_code_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      credit_r     <= CREDIT_WIDTH'(TRACE_CREDITS);
      trace_v_o    <= 1'b0;
      drop_count_o <= '0;
    end
    else
    begin
      credit_r  <= credit_n;
      trace_v_o <= send;
      if (drop && !(&drop_count_o))
      begin
        drop_count_o <= drop_count_o + 1'b1;
      end
    end
  end

  // Record fields hold until the next send
  always_ff @(posedge clk_i)
  begin
    if (send)
    begin
      trace_kind_o    <= commit_v_i ? TRACE_KIND_INSTR : TRACE_KIND_STALL;
      trace_cycle_o   <= cycle_r;
      trace_payload_o <= payload_n;
    end
  end

endmodule

// ==== verilog/stall_histogram.sv ====
`timescale 1ns/10ps

module stall_histogram
  import stall_event_pkg::*;
  import trace_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   freeze_i,
  input  logic [NUM_REASONS-1:0] attrib_vec_i,
  input  logic                   commit_v_i,
  input  stall_reason_e          hist_sel_i,
  output stall_reason_e          reason_code_o,
  output logic [HIST_WIDTH-1:0]  hist_count_o
);

  logic [HIST_WIDTH-1:0] hist_r [NUM_REASONS];
  logic                  count_en;

  // Lowest index wins, empty vector reads as unknown
  always_comb
  begin
    reason_code_o = e_unknown;
    for (int i = NUM_REASONS - 1; i >= 0; i--)
    begin
      if (attrib_vec_i[i])
      begin
        reason_code_o = stall_reason_e'(i);
      end
    end
  end

  // Only cycles that retired nothing are stalls
  assign count_en = ~freeze_i & ~commit_v_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < NUM_REASONS; i++)
      begin
        hist_r[i] <= '0;
      end
    end
    else if (count_en && !(&hist_r[reason_code_o]))
    begin
      hist_r[reason_code_o] <= hist_r[reason_code_o] + 1'b1;
    end
  end

  // Codes above the last reason read as zero
  always_comb
  begin
    if (int'(hist_sel_i) < NUM_REASONS)
    begin
      hist_count_o = hist_r[hist_sel_i];
    end
    else
    begin
      hist_count_o = '0;
    end
  end

endmodule

// ==== verilog/stall_attrib_pipe.sv ====
`timescale 1ns/10ps

module stall_attrib_pipe
  import stall_event_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   freeze_i,
  input  logic [NUM_REASONS-1:0] stall_events_i,
  output logic [NUM_REASONS-1:0] attrib_vec_o
);

  logic [NUM_STAGES-1:0][NUM_REASONS-1:0] stage_r;
  logic [NUM_STAGES-1:0][NUM_REASONS-1:0] stage_n;

  // Shift down one stage and add the events that hold each stage
  always_comb
  begin
    for (int i = 0; i < NUM_STAGES; i++)
    begin
      if (i == 0)
      begin
        stage_n[i] = '0;
      end
      else
      begin
        stage_n[i] = stage_r[i-1];
      end
      stage_n[i] = stage_n[i] | (stall_events_i & STAGE_MASK[i]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i | freeze_i)
    begin
      stage_r <= '0;
    end
    else
    begin
      stage_r <= stage_n;
    end
  end

  assign attrib_vec_o = stage_r[NUM_STAGES-1];

endmodule

// ==== verilog/trace_pkg.sv ====
package trace_pkg;

  import stall_event_pkg::*;

  localparam int PC_WIDTH    = 39;
  localparam int CYCLE_WIDTH = 30;
  localparam int HIST_WIDTH  = 32;
  localparam int DROP_WIDTH  = 32;

  localparam int TRACE_CREDITS = 4;
  localparam int CREDIT_WIDTH  = $clog2(TRACE_CREDITS + 2);

  // Record kind
  localparam logic TRACE_KIND_INSTR = 1'b0;
  localparam logic TRACE_KIND_STALL = 1'b1;

  typedef struct packed
  {
    logic [PC_WIDTH-REASON_WIDTH-1:0] pad;
    stall_reason_e                    code;
  } trace_stall_s;

  // Retired PC or reason, chosen by the record kind
  typedef union packed
  {
    logic [PC_WIDTH-1:0] pc;
    trace_stall_s        stall;
  } trace_payload_u;

endpackage

// ==== verilog/stall_event_pkg.sv ====
package stall_event_pkg;

  localparam int NUM_REASONS  = 25;
  localparam int REASON_WIDTH = 5;
  localparam int NUM_STAGES   = 8;

  // Code equals bit index in every event vector
  typedef enum logic [REASON_WIDTH-1:0]
  {
    e_unknown           = 5'd0,
    e_interrupt         = 5'd1,
    e_exception         = 5'd2,
    e_eret              = 5'd3,
    e_long_haz          = 5'd4,
    e_dcache_rollback   = 5'd5,
    e_dcache_miss       = 5'd6,
    e_dtlb_miss         = 5'd7,
    e_struct_haz        = 5'd8,
    e_mul_dep           = 5'd9,
    e_load_dep          = 5'd10,
    e_data_haz          = 5'd11,
    e_control_haz       = 5'd12,
    e_mispredict        = 5'd13,
    e_fe_cmd_fence      = 5'd14,
    e_fe_cmd            = 5'd15,
    e_misaligned_fetch  = 5'd16,
    e_ret_override      = 5'd17,
    e_branch_override   = 5'd18,
    e_icache_fence      = 5'd19,
    e_icache_rollback   = 5'd20,
    e_icache_miss       = 5'd21,
    e_itlb_miss         = 5'd22,
    e_fe_wait_stall     = 5'd23,
    e_fe_queue_stall    = 5'd24
  } stall_reason_e;

  function automatic logic [NUM_REASONS-1:0] reason_bit(input stall_reason_e r);
    return {{(NUM_REASONS-1){1'b0}}, 1'b1} << r;
  endfunction

  // Traps hold every stage up to EX3
  localparam logic [NUM_REASONS-1:0] TRAP_MASK =
    reason_bit(e_exception) | reason_bit(e_eret) | reason_bit(e_interrupt);

  localparam logic [NUM_REASONS-1:0] IF1_MASK = TRAP_MASK
    | reason_bit(e_fe_wait_stall) | reason_bit(e_fe_queue_stall) | reason_bit(e_itlb_miss)
    | reason_bit(e_icache_rollback) | reason_bit(e_icache_miss) | reason_bit(e_icache_fence)
    | reason_bit(e_fe_cmd);

  localparam logic [NUM_REASONS-1:0] IF2_MASK = TRAP_MASK
    | reason_bit(e_fe_queue_stall) | reason_bit(e_itlb_miss) | reason_bit(e_icache_rollback)
    | reason_bit(e_icache_fence) | reason_bit(e_misaligned_fetch) | reason_bit(e_fe_cmd)
    | reason_bit(e_mispredict);

  localparam logic [NUM_REASONS-1:0] ISD_MASK = TRAP_MASK
    | reason_bit(e_mispredict) | reason_bit(e_itlb_miss) | reason_bit(e_icache_rollback)
    | reason_bit(e_icache_fence) | reason_bit(e_fe_cmd) | reason_bit(e_dcache_rollback)
    | reason_bit(e_branch_override) | reason_bit(e_ret_override);

  localparam logic [NUM_REASONS-1:0] EX1_MASK = TRAP_MASK
    | reason_bit(e_fe_cmd_fence) | reason_bit(e_icache_rollback) | reason_bit(e_mispredict)
    | reason_bit(e_dcache_miss) | reason_bit(e_long_haz) | reason_bit(e_mul_dep)
    | reason_bit(e_data_haz) | reason_bit(e_struct_haz) | reason_bit(e_control_haz)
    | reason_bit(e_load_dep) | reason_bit(e_dcache_rollback);

  // Control hazards span EX1 to EX3
  localparam logic [NUM_REASONS-1:0] EX2_MASK = TRAP_MASK
    | reason_bit(e_mispredict) | reason_bit(e_control_haz) | reason_bit(e_dcache_rollback);

  localparam logic [NUM_REASONS-1:0] EX3_MASK = TRAP_MASK
    | reason_bit(e_control_haz) | reason_bit(e_dcache_rollback);

  // Drain stages take nothing
  localparam logic [NUM_STAGES-1:0][NUM_REASONS-1:0] STAGE_MASK =
    '{'0, '0, EX3_MASK, EX2_MASK, EX1_MASK, ISD_MASK, IF2_MASK, IF1_MASK};

endpackage
